// File: hdl/rename_pkg.sv
/*
    rename package: register index widths, group sizes and the
    request, response, dependency and free structs of the rename stage
*/

`default_nettype none

package rename_pkg;

    // --------------------
    // sizes
    localparam int RENAME_WAYS = 4;
    localparam int AR_WIDTH    = 5;
    localparam int PR_WIDTH    = 6;
    localparam int NUM_AR      = 1 << AR_WIDTH;
    localparam int FREE_DEPTH  = 32;
    // a, b and dest lookups per way
    localparam int RD_PORTS    = 3 * RENAME_WAYS;

    // --------------------
    // index types
    typedef logic [AR_WIDTH-1:0] ar_t;
    typedef logic [PR_WIDTH-1:0] pr_t;
    typedef logic [$clog2(RENAME_WAYS)-1:0] way_sel_t;

    // one way of the incoming group
    typedef struct packed {
        logic valid;
        ar_t  a_ar;
        ar_t  b_ar;
        ar_t  dest_ar;
    } rename_req_t;

    // one way of the renamed group
    typedef struct packed {
        logic valid;
        pr_t  a_pr;
        pr_t  b_pr;
        pr_t  dest_pr;
        pr_t  old_dest_pr;
        logic a_dep;
        logic b_dep;
    } rename_resp_t;

    // checker result per way
    typedef struct packed {
        logic     a_dep;
        way_sel_t a_sel;
        logic     b_dep;
        way_sel_t b_sel;
    } dep_t;

    // released physical register
    typedef struct packed {
        logic valid;
        pr_t  pr;
    } pr_free_t;

endpackage

`default_nettype wire

// File: hdl/ar_dep_check.sv
/*
    ar dependency check: finds read-after-write hazards between ways
    of one rename group and picks the youngest older writer
*/

`timescale 1ns/1ns
`default_nettype none

module ar_dep_check import rename_pkg::*; (
    input  rename_req_t [RENAME_WAYS-1:0] group,
    output dep_t        [RENAME_WAYS-1:0] dep,
    output logic        [RENAME_WAYS-1:0] dest_dep,
    output way_sel_t    [RENAME_WAYS-1:0] dest_sel
);

    // --------------------
    // writer search

    // {hit, sel} for one register against the ways older than way
    function automatic logic [$bits(way_sel_t):0] youngest_writer(
        input rename_req_t [RENAME_WAYS-1:0] grp,
        input int                            way,
        input ar_t                           src
    );
        logic [$bits(way_sel_t):0] hit;
        hit = '0;
        // ascending scan so a younger match overwrites an older one
        for (int j = 0; j < RENAME_WAYS; j++) begin
            if (j < way) begin
                // ar 0 is hardwired, never a producer
                if (grp[j].valid && (grp[j].dest_ar != '0) &&
                    (grp[j].dest_ar == src)) begin
                    hit = {1'b1, way_sel_t'(j)};
                end
            end
        end
        return hit;
    endfunction

    // --------------------
    // per way compares

    always_comb begin
        dep      = '0;
        dest_dep = '0;
        dest_sel = '0;
        for (int i = 0; i < RENAME_WAYS; i++) begin
            // source a
            {dep[i].a_dep, dep[i].a_sel} = youngest_writer(group, i, group[i].a_ar);
            // source b
            {dep[i].b_dep, dep[i].b_sel} = youngest_writer(group, i, group[i].b_ar);
            // destination, gives the previous mapping for old_dest_pr
            {dest_dep[i], dest_sel[i]} = youngest_writer(group, i, group[i].dest_ar);
        end
    end

    // way 0 has no older way, so its flags stay low
    // way 3 may match any of ways 0 to 2

endmodule

`default_nettype wire

// File: hdl/rename_map_table.sv
/*
    register alias table: ar to pr mapping with combinational reads
    and a group write where the youngest writer of a register wins
*/

`timescale 1ns/1ns
`default_nettype none

module rename_map_table import rename_pkg::*; (
    input  logic                        CLK,
    input  logic                        nRST,

    // read ports, three per way
    input  ar_t  [RD_PORTS-1:0]         rd_ar,
    output pr_t  [RD_PORTS-1:0]         rd_pr,

    // write ports, one per way
    input  logic [RENAME_WAYS-1:0]      wr_en,
    input  ar_t  [RENAME_WAYS-1:0]      wr_ar,
    input  pr_t  [RENAME_WAYS-1:0]      wr_pr
);

    // --------------------
    // mapping storage

    // entry 0 is loaded with 0 and never written
    pr_t map_q [NUM_AR];

    // --------------------
    // update

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            // identity map after reset
            for (int i = 0; i < NUM_AR; i++) begin
                map_q[i] <= pr_t'(i);
            end
        end
        else begin
            // way order, later assignment wins for a shared ar
            for (int w = 0; w < RENAME_WAYS; w++) begin
                if (wr_en[w] && (wr_ar[w] != '0)) begin
                    map_q[wr_ar[w]] <= wr_pr[w];
                end
            end
        end
    end

    // --------------------
    // lookup

    // plain reads, ar 0 returns pr 0 from the untouched entry
    always_comb begin
        for (int k = 0; k < RD_PORTS; k++) begin
            rd_pr[k] = map_q[rd_ar[k]];
        end
    end

    // writes show up in the reads after the edge,
    // the stage forwards same-group producers itself

endmodule

`default_nettype wire

// File: hdl/pr_free_list.sv
/*
    physical register free list: circular FIFO that offers four head
    entries for allocation and takes one released register per cycle
*/

`timescale 1ns/1ns
`default_nettype none

module pr_free_list import rename_pkg::*; (
    input  logic                               CLK,
    input  logic                               nRST,

    // allocation side
    input  logic                               alloc,
    input  logic [$clog2(RENAME_WAYS):0]       alloc_count,
    output pr_t  [RENAME_WAYS-1:0]             alloc_pr,
    output logic [$clog2(FREE_DEPTH):0]        free_count,

    // release side
    input  pr_free_t                           free_in
);

    localparam int PTR_WIDTH = $clog2(FREE_DEPTH);

    // --------------------
    // state

    pr_t                     fifo_q [FREE_DEPTH];
    logic [PTR_WIDTH-1:0]    head_q;
    logic [PTR_WIDTH-1:0]    tail_q;
    logic [PTR_WIDTH:0]      count_q;

    // entries popped this cycle
    logic [$clog2(RENAME_WAYS):0] pop_num;

    assign pop_num = alloc ? alloc_count : '0;

    // --------------------
    // head window

    // pointer wraps on its own, depth is a power of two
    always_comb begin
        for (int k = 0; k < RENAME_WAYS; k++) begin
            alloc_pr[k] = fifo_q[head_q + PTR_WIDTH'(k)];
        end
    end

    // count before this cycle's free
    assign free_count = count_q;

    // --------------------
    // pointers and storage

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            // upper half of the pr space starts free
            for (int i = 0; i < FREE_DEPTH; i++) begin
                fifo_q[i] <= pr_t'(NUM_AR + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (PTR_WIDTH+1)'(FREE_DEPTH);
        end
        else begin
            // pop from head
            head_q <= head_q + PTR_WIDTH'(pop_num);
            // push at tail
            if (free_in.valid) begin
                fifo_q[tail_q] <= free_in.pr;
                tail_q         <= tail_q + 1'b1;
            end
            // net occupancy change
            count_q <= count_q - (PTR_WIDTH+1)'(pop_num)
                               + (PTR_WIDTH+1)'(free_in.valid);
        end
    end

endmodule

`default_nettype wire

// File: hdl/rename_stage.sv
/*
    rename stage top: registers the group, checks free space, allocates,
    forwards in-group producers and registers the renamed group
*/

`timescale 1ns/1ns
`default_nettype none

module rename_stage import rename_pkg::*; (
    input  logic                               CLK,
    input  logic                               nRST,
    input  rename_req_t  [RENAME_WAYS-1:0]     next_group,
    input  pr_free_t                           next_free,
    output rename_resp_t [RENAME_WAYS-1:0]     last_group,
    output logic                               last_stall
);

    // --------------------
    // internal signals

    rename_req_t  [RENAME_WAYS-1:0]   group_q;
    pr_free_t                         free_q;
    dep_t         [RENAME_WAYS-1:0]   dep;
    logic         [RENAME_WAYS-1:0]   dest_dep;
    way_sel_t     [RENAME_WAYS-1:0]   dest_sel;
    ar_t          [RD_PORTS-1:0]      rd_ar;
    pr_t          [RD_PORTS-1:0]      rd_pr;
    pr_t          [RENAME_WAYS-1:0]   alloc_pr;
    logic [$clog2(FREE_DEPTH):0]      free_count;
    logic [RENAME_WAYS-1:0]           need_alloc;
    logic [$clog2(RENAME_WAYS):0]     demand;
    logic                             stall;
    pr_t          [RENAME_WAYS-1:0]   dest_pr;
    rename_resp_t [RENAME_WAYS-1:0]   resp;

    ar_dep_check dep_check_inst (.group(group_q), .dep, .dest_dep, .dest_sel);

    // a, b, dest lookups per way
    always_comb begin
        for (int i = 0; i < RENAME_WAYS; i++) begin
            rd_ar[3*i]   = group_q[i].a_ar;
            rd_ar[3*i+1] = group_q[i].b_ar;
            rd_ar[3*i+2] = group_q[i].dest_ar;
        end
    end

    // --------------------
    // allocation

    // demand is valid ways writing a real register, skip ways take pr 0
    always_comb begin
        demand  = '0;
        dest_pr = '0;
        for (int i = 0; i < RENAME_WAYS; i++) begin
            need_alloc[i] = group_q[i].valid && (group_q[i].dest_ar != '0);
            if (need_alloc[i]) begin
                dest_pr[i] = alloc_pr[demand[$clog2(RENAME_WAYS)-1:0]];
                demand     = demand + 1'b1;
            end
        end
    end

    // whole group or nothing
    assign stall = ($bits(free_count))'(demand) > free_count;

    rename_map_table map_table_inst (
        .CLK, .nRST, .rd_ar, .rd_pr,
        .wr_en(need_alloc & {RENAME_WAYS{~stall}}),
        .wr_ar({group_q[3].dest_ar, group_q[2].dest_ar,
                group_q[1].dest_ar, group_q[0].dest_ar}),
        .wr_pr(dest_pr)
    );

    pr_free_list free_list_inst (
        .CLK, .nRST, .alloc(~stall && (demand != '0)), .alloc_count(demand),
        .alloc_pr, .free_count, .free_in(free_q)
    );

    // --------------------
    // forwarding

    always_comb begin
        resp = '0;
        for (int i = 0; i < RENAME_WAYS; i++) begin
            resp[i].valid       = group_q[i].valid && ~stall;
            resp[i].a_dep       = dep[i].a_dep;
            resp[i].b_dep       = dep[i].b_dep;
            resp[i].dest_pr     = dest_pr[i];
            resp[i].a_pr        = dep[i].a_dep ? dest_pr[dep[i].a_sel] : rd_pr[3*i];
            resp[i].b_pr        = dep[i].b_dep ? dest_pr[dep[i].b_sel] : rd_pr[3*i+1];
            resp[i].old_dest_pr = dest_dep[i] ? dest_pr[dest_sel[i]] : rd_pr[3*i+2];
        end
        // rejected group leaves as all invalid
        if (stall) begin
            resp = '0;
        end
    end

    // --------------------
    // entry and exit registers

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            group_q    <= '0;
            free_q     <= '0;
            last_group <= '0;
            last_stall <= 1'b0;
        end
        else begin
            group_q    <= next_group;
            free_q     <= next_free;
            last_group <= resp;
            last_stall <= stall;
        end
    end

endmodule

`default_nettype wire

// File: dv/rename_stage_properties.sv
/*
    rename stage assertions: stall and valid consistency, allocated
    destinations and output values while reset is held
*/

`timescale 1ns/1ns
`default_nettype none

module rename_stage_properties import rename_pkg::*; (
    input logic                               CLK,
    input logic                               nRST,
    input rename_req_t  [RENAME_WAYS-1:0]     group_q,
    input rename_resp_t [RENAME_WAYS-1:0]     last_group,
    input logic                               last_stall
);

    logic [RENAME_WAYS-1:0] out_valid;

    always_comb begin
        for (int i = 0; i < RENAME_WAYS; i++) begin
            out_valid[i] = last_group[i].valid;
        end
    end

    // a rejected group leaves with no valid way
    stall_clears_valid: assert property (@(posedge CLK) disable iff (!nRST)
        last_stall |-> (out_valid == '0))
        else $error("stall seen together with valid ways");

    // real destinations always get a real register
    for (genvar w = 0; w < RENAME_WAYS; w++) begin : g_way
        dest_allocated: assert property (@(posedge CLK) disable iff (!nRST)
            (last_group[w].valid && ($past(group_q[w].dest_ar) != '0))
            |-> (last_group[w].dest_pr != '0))
            else $error("valid way %0d shows dest_pr 0 for a real destination", w);
    end

    // same group rejected on two cycles in a row
    stall_not_repeated: assert property (@(posedge CLK) disable iff (!nRST)
        (last_stall && $past(last_stall)) |-> ($past(group_q) != $past(group_q, 2)))
        else $error("same group stalled on two consecutive cycles");

    // outputs held low while in reset
    reset_outputs_low: assert property (@(posedge CLK)
        !nRST |-> ((last_group == '0) && !last_stall))
        else $error("outputs not low during reset");

endmodule

bind rename_stage rename_stage_properties props_inst (
    .CLK(CLK),
    .nRST(nRST),
    .group_q(group_q),
    .last_group(last_group),
    .last_stall(last_stall)
);

`default_nettype wire

// File: dv/rename_stage_tb.sv
/*
    rename stage testbench: pattern file driven groups on the falling
    edge, results compared two rising edges later
*/

`timescale 1ns/1ns
`default_nettype none

module rename_stage_tb import rename_pkg::*; ();

    localparam int    CLK_HALF      = 2;
    localparam int    RESET_CYCLES  = 2;
    localparam int    MAX_GAP       = 2;
    localparam int    DRAIN_TIMEOUT = 20;
    localparam string PATTERN_FILE  = "dv/rename_patterns.txt";

    typedef rename_req_t  [RENAME_WAYS-1:0] req_group_t;
    typedef rename_resp_t [RENAME_WAYS-1:0] resp_group_t;

    logic        CLK;
    logic        nRST;
    req_group_t  next_group;
    pr_free_t    next_free;
    resp_group_t last_group;
    logic        last_stall;

    // patterns as read from the file
    req_group_t  pat_group  [$];
    pr_free_t    pat_free   [$];
    resp_group_t pat_expect [$];
    logic        pat_stall  [$];

    // driven cycles still waiting for their result
    resp_group_t inflight_group [$];
    logic        inflight_stall [$];
    int          inflight_due   [$];
    int          inflight_idx   [$];
    int          cycle;

    rename_stage rename_stage_inst (
        .CLK(CLK),
        .nRST(nRST),
        .next_group(next_group),
        .next_free(next_free),
        .last_group(last_group),
        .last_stall(last_stall)
    );

    initial begin
        CLK = 1'b0;
        forever #CLK_HALF CLK = ~CLK;
    end

    // --------------------
    // failure and compares

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first failure");
    endtask

    function automatic string resp_text(input rename_resp_t r);
        return $sformatf("v=%0b a=%0h b=%0h d=%0h old=%0h dep=%0b%0b", r.valid, r.a_pr,
                         r.b_pr, r.dest_pr, r.old_dest_pr, r.a_dep, r.b_dep);
    endfunction

    // whole group, reported per way
    task automatic check_group(input resp_group_t got, input resp_group_t exp, input int idx);
        for (int w = 0; w < RENAME_WAYS; w++) begin
            if (got[w] !== exp[w]) begin
                abort_run($sformatf("ERROR @ %0t ns: pattern %0d way %0d got %s expected %s",
                                    $time, idx, w, resp_text(got[w]), resp_text(exp[w])));
            end
        end
    endtask

    task automatic check_stall(input logic got, input logic exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("ERROR @ %0t ns: pattern %0d last_stall got %0b expected %0b",
                                $time, idx, got, exp));
        end
    endtask

    // --------------------
    // pattern file

    // request token is {v, a, b, dest}, one byte per register
    function automatic rename_req_t unpack_req(input logic [27:0] tok);
        rename_req_t r;
        r.valid   = tok[24];
        r.a_ar    = tok[20:16];
        r.b_ar    = tok[12:8];
        r.dest_ar = tok[4:0];
        return r;
    endfunction

    // expected token is {v, a, b, dest, old, deps}
    function automatic rename_resp_t unpack_resp(input logic [39:0] tok);
        rename_resp_t r;
        r.valid       = tok[36];
        r.a_pr        = tok[33:28];
        r.b_pr        = tok[25:20];
        r.dest_pr     = tok[17:12];
        r.old_dest_pr = tok[9:4];
        r.a_dep       = tok[1];
        r.b_dep       = tok[0];
        return r;
    endfunction

    function automatic pr_free_t unpack_free(input logic [11:0] tok);
        pr_free_t f;
        f.valid = tok[8];
        f.pr    = tok[5:0];
        return f;
    endfunction

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [27:0] req_tok  [RENAME_WAYS];
        logic [11:0] free_tok;
        logic [39:0] resp_tok [RENAME_WAYS];
        logic [3:0]  stall_tok;
        req_group_t  grp;
        resp_group_t exp;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            abort_run($sformatf("could not open pattern file %s", PATTERN_FILE));
        end
        else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // skip comments and blank lines
                if ((n > 0) && (line.len() > 1) && (line[0] != "#")) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                                req_tok[0], req_tok[1], req_tok[2], req_tok[3], free_tok,
                                resp_tok[0], resp_tok[1], resp_tok[2], resp_tok[3], stall_tok);
                    if (n != 10) begin
                        abort_run($sformatf("malformed pattern line: %s", line));
                    end
                    else begin
                        for (int w = 0; w < RENAME_WAYS; w++) begin
                            grp[w] = unpack_req(req_tok[w]);
                            exp[w] = unpack_resp(resp_tok[w]);
                        end
                        pat_group.push_back(grp);
                        pat_free.push_back(unpack_free(free_tok));
                        pat_expect.push_back(exp);
                        pat_stall.push_back(stall_tok[0]);
                    end
                end
            end
            $fclose(fd);
            if (pat_group.size() == 0) begin
                abort_run("pattern file holds no patterns");
            end
        end
    endtask

    // --------------------
    // cycle driver

    // oldest in-flight result is due two falling edges after it was driven
    task automatic compare_due();
        if ((inflight_due.size() != 0) && (inflight_due[0] == cycle)) begin
            check_group(last_group, inflight_group[0], inflight_idx[0]);
            check_stall(last_stall, inflight_stall[0], inflight_idx[0]);
            void'(inflight_group.pop_front());
            void'(inflight_stall.pop_front());
            void'(inflight_due.pop_front());
            void'(inflight_idx.pop_front());
        end
    endtask

    task automatic step_cycle(input req_group_t grp, input pr_free_t fr,
                              input resp_group_t exp, input logic stl, input int idx);
        @(negedge CLK);
        cycle = cycle + 1;
        compare_due();
        next_group = grp;
        next_free  = fr;
        inflight_group.push_back(exp);
        inflight_stall.push_back(stl);
        inflight_due.push_back(cycle + 2);
        inflight_idx.push_back(idx);
    endtask

    // --------------------
    // main sequence

    initial begin
        int gap;
        int waited;
        void'($urandom(32'hc03bdae8));
        nRST       = 1'b0;
        next_group = '0;
        next_free  = '0;
        cycle      = 0;
        load_patterns();
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        // one edge out of reset with an empty group
        @(negedge CLK);
        check_group(last_group, '0, -1);
        check_stall(last_stall, 1'b0, -1);
        for (int p = 0; p < pat_group.size(); p++) begin
            // idle gap, valid low, no free
            gap = $urandom_range(MAX_GAP, 0);
            repeat (gap) begin
                step_cycle('0, '0, '0, 1'b0, -1);
            end
            step_cycle(pat_group[p], pat_free[p], pat_expect[p], pat_stall[p], p);
        end
        // drain the last two groups
        waited = 0;
        while ((inflight_due.size() != 0) && (waited < DRAIN_TIMEOUT)) begin
            @(negedge CLK);
            cycle      = cycle + 1;
            next_group = '0;
            next_free  = '0;
            compare_due();
            waited = waited + 1;
        end
        if (inflight_due.size() != 0) begin
            abort_run($sformatf("pipeline never drained, %0d results still outstanding",
                                inflight_due.size()));
        end
        else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
hdl/rename_pkg.sv
hdl/ar_dep_check.sv
hdl/rename_map_table.sv
hdl/pr_free_list.sv
hdl/rename_stage.sv
dv/rename_stage_properties.sv
dv/rename_stage_tb.sv

// File: Makefile
# verilator build and run of the rename stage testbench

SOURCES := $(shell cat list.f)
BIN     := obj_dir/Vrename_stage_tb

.PHONY: all run clean

all: run

$(BIN): list.f $(SOURCES)
	verilator --binary --assert -Wno-fatal --top-module rename_stage_tb \
		-f list.f -Mdir obj_dir

run: $(BIN) dv/rename_patterns.txt
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/rename_patterns.txt
# columns: four request ways {v, a_ar, b_ar, dest_ar}, free {v, pr}, then four expected
# ways {v, a_pr, b_pr, dest_pr, old_dest_pr, a_dep b_dep} and stall; hex, 2 digits per reg
#
# independent group on the reset free list
1010203 1040506 1070809 10a0b0c 000 1010220030 1040521060 1070822090 10a0b230c0 0
# in-group producers, youngest older writer wins
1010205 1050305 1050607 1070508 000 1010224050 1242025242 1252126072 1262527083 0
# mappings from earlier groups, dest rewritten inside the group
1050703 1080906 1030c09 10c0103 000 1252628200 1272229210 128232a222 123012b280 0
# ar 0 as source and destination
1000300 100000a 10a0000 1000a01 000 1002b00000 100002c0a0 12c0000002 1002c2d011 0
#
# drain the free list down to two entries
1000010 1000011 1000012 1000013 000 100002e100 100002f110 1000030120 1000031130 0
1000014 1000015 1000016 1000017 000 1000032140 1000033150 1000034160 1000035170 0
1000018 1000019 100001a 100001b 000 1000036180 1000037190 10000381a0 10000391b0 0
100001c 100001d 100001e 100001f 000 100003a1c0 100003b1d0 100003c1e0 100003d1f0 0
#
# three needed with two free, stall, pr 03 released
1010002 1020004 104000b 0000000 103 0000000000 0000000000 0000000000 0000000000 1
# same group again takes 3e 3f 03, pr 06 released
1010002 1020004 104000b 0000000 106 12d003e020 13e003f042 13f00030b2 0000000000 0
# pr 06 comes out next
1000005 1050000 0000000 0000000 000 1000006250 1060000002 0000000000 0000000000 0
# free list empty again
1000007 0000000 0000000 0000000 000 0000000000 0000000000 0000000000 0000000000 1
